// ==== ifmap_pkg.sv ====
package ifmap_pkg;

    // index widths follow the largest tensor shape the accelerator handles
    typedef logic [7:0] row_t;      // D and the row index
    typedef logic [7:0] col_t;      // W and the column index
    typedef logic [2:0] batch_t;    // n and the map index
    typedef logic [2:0] chan_sub_t; // q, channels in one group
    typedef logic [1:0] chan_grp_t; // r, number of groups

    // combined channel index, sub-channel plus group times q
    typedef logic [4:0] chan_t;

    typedef logic [1:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    localparam cfg_addr_t REG_SHAPE = 2'd0; // D in 7..0, W in 15..8
    localparam cfg_addr_t REG_CHAN  = 2'd1; // n in 2..0, q in 6..4, r in 9..8
    localparam cfg_addr_t REG_BASE  = 2'd2;
    localparam cfg_addr_t REG_CTRL  = 2'd3;

    // bit 0 means start on a write and busy on a read
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_BUSY_BIT  = 0;
    localparam int CTRL_DONE_BIT  = 1;

    typedef enum logic [1:0] {
        IDLE,
        LOOPING,
        DONE
    } gen_state_t;

endpackage

// ==== ifmap_cfg_regs.sv ====
module ifmap_cfg_regs #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_write,
    input  ifmap_pkg::cfg_addr_t cfg_addr,
    input  ifmap_pkg::cfg_data_t cfg_wdata,
    input  logic                 busy,
    input  logic                 done,
    output ifmap_pkg::cfg_data_t cfg_rdata,
    output ifmap_pkg::row_t      d_count,
    output ifmap_pkg::col_t      w_count,
    output ifmap_pkg::batch_t    n_count,
    output ifmap_pkg::chan_sub_t q_count,
    output ifmap_pkg::chan_grp_t r_count,
    output logic [ADDR_WIDTH-1:0] base_addr,
    output logic                 start
);

    logic start_write;
    logic done_sticky;

    assign start_write = cfg_write && (cfg_addr == ifmap_pkg::REG_CTRL) &&
                         cfg_wdata[ifmap_pkg::CTRL_START_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            d_count     <= '0;
            w_count     <= '0;
            n_count     <= '0;
            q_count     <= '0;
            r_count     <= '0;
            base_addr   <= '0;
            start       <= 1'b0;
            done_sticky <= 1'b0;
        end else begin
            start <= start_write; // one-cycle pulse after the write

            // a new run clears the flag even if done arrives in the same cycle
            if (start_write) begin
                done_sticky <= 1'b0;
            end else if (done) begin
                done_sticky <= 1'b1;
            end

            if (cfg_write) begin
                case (cfg_addr)
                    ifmap_pkg::REG_SHAPE: begin
                        d_count <= cfg_wdata[7:0];
                        w_count <= cfg_wdata[15:8];
                    end
                    ifmap_pkg::REG_CHAN: begin
                        n_count <= cfg_wdata[2:0];
                        q_count <= cfg_wdata[6:4];
                        r_count <= cfg_wdata[9:8];
                    end
                    ifmap_pkg::REG_BASE: base_addr <= cfg_wdata[ADDR_WIDTH-1:0];
                    default: ; // control writes only make the start pulse
                endcase
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            ifmap_pkg::REG_SHAPE: begin
                cfg_rdata[7:0]  = d_count;
                cfg_rdata[15:8] = w_count;
            end
            ifmap_pkg::REG_CHAN: begin
                cfg_rdata[2:0] = n_count;
                cfg_rdata[6:4] = q_count;
                cfg_rdata[9:8] = r_count;
            end
            ifmap_pkg::REG_BASE: cfg_rdata = ifmap_pkg::cfg_data_t'(base_addr);
            ifmap_pkg::REG_CTRL: begin
                // report busy already in the cycle the start pulse is out
                cfg_rdata[ifmap_pkg::CTRL_BUSY_BIT] = busy || start;
                cfg_rdata[ifmap_pkg::CTRL_DONE_BIT] = done_sticky;
            end
        endcase
    end

endmodule

// ==== ifmap_index_generator.sv ====
module ifmap_index_generator (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  ifmap_pkg::row_t      d_count,
    input  ifmap_pkg::col_t      w_count,
    input  ifmap_pkg::batch_t    n_count,
    input  ifmap_pkg::chan_sub_t q_count,
    input  ifmap_pkg::chan_grp_t r_count,
    input  logic                 idx_ready,
    output logic                 busy,
    output logic                 done,
    output logic                 idx_valid,
    output ifmap_pkg::batch_t    idx_batch,
    output ifmap_pkg::chan_t     idx_chan,
    output ifmap_pkg::row_t      idx_row,
    output ifmap_pkg::col_t      idx_col
);

    ifmap_pkg::gen_state_t state, state_nxt;

    ifmap_pkg::row_t      d_cnt, d_nxt;
    ifmap_pkg::col_t      w_cnt, w_nxt;
    ifmap_pkg::batch_t    n_cnt, n_nxt;
    ifmap_pkg::chan_sub_t q_cnt, q_nxt;
    ifmap_pkg::chan_grp_t r_cnt, r_nxt;

    logic fire;
    logic r_last, d_last, q_last, w_last, n_last;

    assign fire   = idx_valid && idx_ready;
    assign r_last = (r_cnt == r_count - 1'b1);
    assign d_last = (d_cnt == d_count - 1'b1);
    assign q_last = (q_cnt == q_count - 1'b1);
    assign w_last = (w_cnt == w_count - 1'b1);
    assign n_last = (n_cnt == n_count - 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ifmap_pkg::IDLE;
            d_cnt <= '0;
            w_cnt <= '0;
            n_cnt <= '0;
            q_cnt <= '0;
            r_cnt <= '0;
        end else begin
            state <= state_nxt;
            d_cnt <= d_nxt;
            w_cnt <= w_nxt;
            n_cnt <= n_nxt;
            q_cnt <= q_nxt;
            r_cnt <= r_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        d_nxt     = d_cnt;
        w_nxt     = w_cnt;
        n_nxt     = n_cnt;
        q_nxt     = q_cnt;
        r_nxt     = r_cnt;

        case (state)
            ifmap_pkg::IDLE: begin
                if (start) begin
                    state_nxt = ifmap_pkg::LOOPING;
                    d_nxt     = '0;
                    w_nxt     = '0;
                    n_nxt     = '0;
                    q_nxt     = '0;
                    r_nxt     = '0;
                end
            end
            ifmap_pkg::LOOPING: begin
                // r innermost, then row, sub-channel, column and batch map
                if (fire) begin
                    if (!r_last) begin
                        r_nxt = r_cnt + 1'b1;
                    end else begin
                        r_nxt = '0;
                        if (!d_last) begin
                            d_nxt = d_cnt + 1'b1;
                        end else begin
                            d_nxt = '0;
                            if (!q_last) begin
                                q_nxt = q_cnt + 1'b1;
                            end else begin
                                q_nxt = '0;
                                if (!w_last) begin
                                    w_nxt = w_cnt + 1'b1;
                                end else begin
                                    w_nxt = '0;
                                    if (!n_last) begin
                                        n_nxt = n_cnt + 1'b1;
                                    end else begin
                                        n_nxt     = '0;
                                        state_nxt = ifmap_pkg::DONE;
                                    end
                                end
                            end
                        end
                    end
                end
            end
            ifmap_pkg::DONE: state_nxt = ifmap_pkg::IDLE; // done lasts one cycle
            default:         state_nxt = ifmap_pkg::IDLE;
        endcase
    end

    assign idx_valid = (state == ifmap_pkg::LOOPING);
    assign busy      = idx_valid;
    assign done      = (state == ifmap_pkg::DONE);

    assign idx_batch = n_cnt;
    assign idx_chan  = ifmap_pkg::chan_t'(q_cnt) +
                       ifmap_pkg::chan_t'(r_cnt) * ifmap_pkg::chan_t'(q_count);
    assign idx_row   = d_cnt;
    assign idx_col   = w_cnt;

    // a zero count would make the loop nest wrap through the whole index range
    a_nonzero_shape : assert property (@(posedge clk) disable iff (reset)
        (start && state == ifmap_pkg::IDLE) |->
        (d_count != 0 && w_count != 0 && n_count != 0 && q_count != 0 && r_count != 0))
        else $error("zero dimension in shape at start");

    a_idx_hold : assert property (@(posedge clk) disable iff (reset)
        (idx_valid && !idx_ready) |=>
        (idx_valid && $stable({idx_batch, idx_chan, idx_row, idx_col})))
        else $error("index tuple changed while stalled");

endmodule

// ==== ifmap_addr_calc.sv ====
module ifmap_addr_calc #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] base_addr,
    input  ifmap_pkg::row_t       d_count,
    input  ifmap_pkg::col_t       w_count,
    input  ifmap_pkg::chan_sub_t  q_count,
    input  ifmap_pkg::chan_grp_t  r_count,
    input  logic                  idx_valid,
    input  ifmap_pkg::batch_t     idx_batch,
    input  ifmap_pkg::chan_t      idx_chan,
    input  ifmap_pkg::row_t       idx_row,
    input  ifmap_pkg::col_t       idx_col,
    input  logic                  rd_ready,
    output logic                  idx_ready,
    output logic                  rd_valid,
    output logic [ADDR_WIDTH-1:0] rd_addr,
    output ifmap_pkg::batch_t     rd_batch,
    output ifmap_pkg::chan_t      rd_chan,
    output ifmap_pkg::row_t       rd_row,
    output ifmap_pkg::col_t       rd_col
);

    // all arithmetic stays modulo the buffer depth, so the wrap is exact
    logic [ADDR_WIDTH-1:0] chan_total;
    logic [ADDR_WIDTH-1:0] plane;
    logic [ADDR_WIDTH-1:0] line;
    logic [ADDR_WIDTH-1:0] lin_addr;

    assign chan_total = ADDR_WIDTH'(q_count) * ADDR_WIDTH'(r_count);
    assign plane      = ADDR_WIDTH'(idx_batch) * chan_total + ADDR_WIDTH'(idx_chan);
    assign line       = plane * ADDR_WIDTH'(d_count) + ADDR_WIDTH'(idx_row);
    assign lin_addr   = base_addr + line * ADDR_WIDTH'(w_count) + ADDR_WIDTH'(idx_col);

    assign idx_ready = !rd_valid || rd_ready; // take a new tuple as the old one leaves

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else if (idx_ready) begin
            rd_valid <= idx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (idx_valid && idx_ready) begin
            rd_addr  <= lin_addr;
            rd_batch <= idx_batch;
            rd_chan  <= idx_chan;
            rd_row   <= idx_row;
            rd_col   <= idx_col;
        end
    end

    a_rd_hold : assert property (@(posedge clk) disable iff (reset)
        (rd_valid && !rd_ready) |=>
        (rd_valid && $stable({rd_addr, rd_batch, rd_chan, rd_row, rd_col})))
        else $error("read request changed while stalled");

endmodule

// ==== ifmap_buffer.sv ====
module ifmap_buffer #(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_valid,
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  logic [DATA_WIDTH-1:0] load_data,
    input  logic                  rd_valid,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    input  ifmap_pkg::batch_t     rd_batch,
    input  ifmap_pkg::chan_t      rd_chan,
    input  ifmap_pkg::row_t       rd_row,
    input  ifmap_pkg::col_t       rd_col,
    input  logic                  pix_ready,
    output logic                  rd_ready,
    output logic                  pix_valid,
    output logic [DATA_WIDTH-1:0] pix_data,
    output ifmap_pkg::batch_t     pix_batch,
    output ifmap_pkg::chan_t      pix_chan,
    output ifmap_pkg::row_t       pix_row,
    output ifmap_pkg::col_t       pix_col
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic rd_fire;

    assign rd_ready = !pix_valid || pix_ready;
    assign rd_fire  = rd_valid && rd_ready;

    // load port is independent of the read side
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else if (rd_ready) begin
            pix_valid <= rd_valid;
        end
    end

    // a read in the same cycle as a load to that address returns the old word
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            pix_data  <= mem[rd_addr];
            pix_batch <= rd_batch;
            pix_chan  <= rd_chan;
            pix_row   <= rd_row;
            pix_col   <= rd_col;
        end
    end

    a_pix_hold : assert property (@(posedge clk) disable iff (reset)
        (pix_valid && !pix_ready) |=>
        (pix_valid && $stable({pix_data, pix_batch, pix_chan, pix_row, pix_col})))
        else $error("pixel dropped or changed before transfer");

endmodule

// ==== ifmap_fetch_top.sv ====
module ifmap_fetch_top #(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_write,
    input  ifmap_pkg::cfg_addr_t  cfg_addr,
    input  ifmap_pkg::cfg_data_t  cfg_wdata,
    output ifmap_pkg::cfg_data_t  cfg_rdata,
    input  logic                  load_valid,
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  logic [DATA_WIDTH-1:0] load_data,
    output logic                  pix_valid,
    input  logic                  pix_ready,
    output logic [DATA_WIDTH-1:0] pix_data,
    output ifmap_pkg::batch_t     pix_batch,
    output ifmap_pkg::chan_t      pix_chan,
    output ifmap_pkg::row_t       pix_row,
    output ifmap_pkg::col_t       pix_col
);

    ifmap_pkg::row_t       d_count;
    ifmap_pkg::col_t       w_count;
    ifmap_pkg::batch_t     n_count;
    ifmap_pkg::chan_sub_t  q_count;
    ifmap_pkg::chan_grp_t  r_count;
    logic [ADDR_WIDTH-1:0] base_addr;
    logic                  start;
    logic                  busy;
    logic                  done;

    logic                  idx_valid;
    logic                  idx_ready;
    ifmap_pkg::batch_t     idx_batch;
    ifmap_pkg::chan_t      idx_chan;
    ifmap_pkg::row_t       idx_row;
    ifmap_pkg::col_t       idx_col;

    logic                  rd_valid;
    logic                  rd_ready;
    logic [ADDR_WIDTH-1:0] rd_addr;
    ifmap_pkg::batch_t     rd_batch;
    ifmap_pkg::chan_t      rd_chan;
    ifmap_pkg::row_t       rd_row;
    ifmap_pkg::col_t       rd_col;

    ifmap_cfg_regs #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) ifmap_cfg_regs_inst (
        .clk       (clk),
        .reset     (reset),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .done      (done),
        .cfg_rdata (cfg_rdata),
        .d_count   (d_count),
        .w_count   (w_count),
        .n_count   (n_count),
        .q_count   (q_count),
        .r_count   (r_count),
        .base_addr (base_addr),
        .start     (start)
    );

    ifmap_index_generator ifmap_index_generator_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .d_count   (d_count),
        .w_count   (w_count),
        .n_count   (n_count),
        .q_count   (q_count),
        .r_count   (r_count),
        .idx_ready (idx_ready),
        .busy      (busy),
        .done      (done),
        .idx_valid (idx_valid),
        .idx_batch (idx_batch),
        .idx_chan  (idx_chan),
        .idx_row   (idx_row),
        .idx_col   (idx_col)
    );

    ifmap_addr_calc #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) ifmap_addr_calc_inst (
        .clk       (clk),
        .reset     (reset),
        .base_addr (base_addr),
        .d_count   (d_count),
        .w_count   (w_count),
        .q_count   (q_count),
        .r_count   (r_count),
        .idx_valid (idx_valid),
        .idx_batch (idx_batch),
        .idx_chan  (idx_chan),
        .idx_row   (idx_row),
        .idx_col   (idx_col),
        .rd_ready  (rd_ready),
        .idx_ready (idx_ready),
        .rd_valid  (rd_valid),
        .rd_addr   (rd_addr),
        .rd_batch  (rd_batch),
        .rd_chan   (rd_chan),
        .rd_row    (rd_row),
        .rd_col    (rd_col)
    );

    ifmap_buffer #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) ifmap_buffer_inst (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_valid   (rd_valid),
        .rd_addr    (rd_addr),
        .rd_batch   (rd_batch),
        .rd_chan    (rd_chan),
        .rd_row     (rd_row),
        .rd_col     (rd_col),
        .pix_ready  (pix_ready),
        .rd_ready   (rd_ready),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_batch  (pix_batch),
        .pix_chan   (pix_chan),
        .pix_row    (pix_row),
        .pix_col    (pix_col)
    );

endmodule

// ==== tb_ifmap_fetch.sv ====
module tb_ifmap_fetch;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_WIDTH  = 12;
    localparam int DATA_WIDTH  = 8;
    localparam int DEPTH       = 2 ** ADDR_WIDTH;
    localparam int ROWS        = 6;
    localparam int STALL_LIMIT = 200; // cycles without a pixel before giving up

    // each row is one run with D, W, n, q, r, base and the percent chance that pix_ready is low
    localparam int TAB_D     [ROWS] = '{1, 2, 3, 4, 5, 16};
    localparam int TAB_W     [ROWS] = '{1, 3, 2, 4, 3, 16};
    localparam int TAB_N     [ROWS] = '{1, 1, 2, 2, 3, 2};
    localparam int TAB_Q     [ROWS] = '{1, 2, 1, 3, 2, 3};
    localparam int TAB_R     [ROWS] = '{1, 1, 3, 2, 3, 2};
    localparam int TAB_BASE  [ROWS] = '{0, 16, 100, 2000, 4000, 3500};
    localparam int TAB_STALL [ROWS] = '{0, 30, 50, 20, 40, 25};

    logic                  clk;
    logic                  reset;
    logic                  cfg_write;
    ifmap_pkg::cfg_addr_t  cfg_addr;
    ifmap_pkg::cfg_data_t  cfg_wdata;
    ifmap_pkg::cfg_data_t  cfg_rdata;
    logic                  load_valid;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [DATA_WIDTH-1:0] load_data;
    logic                  pix_valid;
    logic                  pix_ready;
    logic [DATA_WIDTH-1:0] pix_data;
    ifmap_pkg::batch_t     pix_batch;
    ifmap_pkg::chan_t      pix_chan;
    ifmap_pkg::row_t       pix_row;
    ifmap_pkg::col_t       pix_col;

    logic [DATA_WIDTH-1:0] model_mem [DEPTH];
    int seed = 32'h3886_d74d;

    int exp_batch [$];
    int exp_chan  [$];
    int exp_row   [$];
    int exp_col   [$];
    int exp_addr  [$];

    ifmap_fetch_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) ifmap_fetch_top_inst (
        .clk        (clk),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix_data   (pix_data),
        .pix_batch  (pix_batch),
        .pix_chan   (pix_chan),
        .pix_row    (pix_row),
        .pix_col    (pix_col)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic write_reg(input ifmap_pkg::cfg_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    // readback is combinational, so sample half way to the next rising edge
    task automatic read_reg(input ifmap_pkg::cfg_addr_t addr, output logic [31:0] data);
        @(negedge clk);
        cfg_write = 1'b0;
        cfg_addr  = addr;
        #5;
        data = cfg_rdata;
    endtask

    task automatic load_memory();
        for (int a = 0; a < DEPTH; a++) begin
            model_mem[a] = DATA_WIDTH'($random(seed));
            @(negedge clk);
            load_valid = 1'b1;
            load_addr  = ADDR_WIDTH'(a);
            load_data  = model_mem[a];
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    // loop order from outside in is n, W, q, D, r
    task automatic build_expected(input int row);
        int chan;
        int addr;
        exp_batch.delete();
        exp_chan.delete();
        exp_row.delete();
        exp_col.delete();
        exp_addr.delete();
        for (int b = 0; b < TAB_N[row]; b++) begin
            for (int w = 0; w < TAB_W[row]; w++) begin
                for (int qi = 0; qi < TAB_Q[row]; qi++) begin
                    for (int d = 0; d < TAB_D[row]; d++) begin
                        for (int ri = 0; ri < TAB_R[row]; ri++) begin
                            chan = qi + ri * TAB_Q[row];
                            addr = TAB_BASE[row] + ((b * TAB_Q[row] * TAB_R[row] + chan)
                                   * TAB_D[row] + d) * TAB_W[row] + w;
                            exp_batch.push_back(b);
                            exp_chan.push_back(chan);
                            exp_row.push_back(d);
                            exp_col.push_back(w);
                            exp_addr.push_back(addr % DEPTH); // the buffer wraps
                        end
                    end
                end
            end
        end
    endtask

    task automatic run_row(input int row);
        logic [31:0] rdata;
        logic [31:0] shape_word;
        logic [31:0] chan_word;
        int total;
        int k;
        int idle;
        bit mid_sent;
        bit done_seen;

        shape_word = {16'd0, 8'(TAB_W[row]), 8'(TAB_D[row])};
        chan_word  = {22'd0, 2'(TAB_R[row]), 1'b0, 3'(TAB_Q[row]), 1'b0, 3'(TAB_N[row])};
        write_reg(ifmap_pkg::REG_SHAPE, shape_word);
        write_reg(ifmap_pkg::REG_CHAN, chan_word);
        write_reg(ifmap_pkg::REG_BASE, 32'(TAB_BASE[row]));
        read_reg(ifmap_pkg::REG_SHAPE, rdata);
        check_value("REG_SHAPE readback", rdata, shape_word);
        read_reg(ifmap_pkg::REG_CHAN, rdata);
        check_value("REG_CHAN readback", rdata, chan_word);
        read_reg(ifmap_pkg::REG_BASE, rdata);
        check_value("REG_BASE readback", rdata, 32'(TAB_BASE[row]));

        build_expected(row);
        total = exp_batch.size();

        write_reg(ifmap_pkg::REG_CTRL, 32'd1);
        read_reg(ifmap_pkg::REG_CTRL, rdata);
        check_value("busy after start", 32'(rdata[0]), 32'd1);
        check_value("done after start", 32'(rdata[1]), 32'd0); // start clears the old done

        k        = 0;
        idle     = 0;
        mid_sent = 1'b0;
        while (k < total) begin
            @(negedge clk);
            cfg_write = 1'b0;
            pix_ready = (($unsigned($random(seed)) % 100) >= TAB_STALL[row]);
            if (!mid_sent && total >= 16 && k == total / 2) begin
                cfg_write = 1'b1; // a second start in the middle of the run
                cfg_addr  = ifmap_pkg::REG_CTRL;
                cfg_wdata = 32'd1;
                mid_sent  = 1'b1;
            end
            if (pix_valid && pix_ready) begin
                check_value($sformatf("pixel %0d batch", k), 32'(pix_batch), exp_batch[k]);
                check_value($sformatf("pixel %0d chan", k), 32'(pix_chan), exp_chan[k]);
                check_value($sformatf("pixel %0d row", k), 32'(pix_row), exp_row[k]);
                check_value($sformatf("pixel %0d col", k), 32'(pix_col), exp_col[k]);
                check_value($sformatf("pixel %0d data", k), 32'(pix_data),
                            32'(model_mem[exp_addr[k]]));
                k++;
                idle = 0;
            end else begin
                idle++;
                if (idle > STALL_LIMIT) begin
                    $display("timeout: no pixel for %0d cycles in run %0d after %0d of %0d",
                             STALL_LIMIT, row, k, total);
                    stop_on_failure();
                end
            end
        end

        // a repeated pixel would show up here
        repeat (4) begin
            @(negedge clk);
            cfg_write = 1'b0;
            pix_ready = 1'b1;
            check_value("pix_valid after the last pixel", 32'(pix_valid), 32'd0);
        end

        done_seen = 1'b0;
        for (int t = 0; t < 50 && !done_seen; t++) begin
            read_reg(ifmap_pkg::REG_CTRL, rdata);
            done_seen = rdata[1];
        end
        if (!done_seen) begin
            $display("timeout: done never set in REG_CTRL after run %0d", row);
            stop_on_failure();
        end
        check_value("busy after run", 32'(rdata[0]), 32'd0);
    endtask

    initial begin
        logic [31:0] rdata;
        reset      = 1'b1;
        cfg_write  = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        pix_ready  = 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("pix_valid after reset", 32'(pix_valid), 32'd0);
        read_reg(ifmap_pkg::REG_CTRL, rdata);
        check_value("REG_CTRL after reset", rdata, 32'd0);

        load_memory();
        for (int row = 0; row < ROWS; row++) begin
            run_row(row);
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== build.f ====
ifmap_pkg.sv
ifmap_cfg_regs.sv
ifmap_index_generator.sv
ifmap_addr_calc.sv
ifmap_buffer.sv
ifmap_fetch_top.sv
tb_ifmap_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ifmap_fetch
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the run counts as passed only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
